//--- rtl/mem_perf_config.svh
// ############################################################
// counter width and data-cache lane count of the monitor
// ############################################################

`ifndef MEM_PERF_CONFIG_SVH
`define MEM_PERF_CONFIG_SVH

// width of every performance counter
// wide enough that a long run never wraps
`define PERF_CTR_BITS 44

// number of data-cache request lanes observed
// one tap per lane, each with its own rw bit
`define DCACHE_NUM_REQS 4

`endif

//--- rtl/mem_bus_pkg.sv
// ############################################################
// bus observation types for the icache and dcache taps
// ############################################################

`include "mem_perf_config.svh"

package mem_bus_pkg;

    // icache handshake pairs, as the monitor sees them
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic rsp_valid;
        logic rsp_ready;
    } icache_tap_t;

    // one dcache lane; req_rw high marks a store
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic req_rw;
        logic rsp_valid;
        logic rsp_ready;
    } dcache_lane_tap_t;

    // all dcache lanes side by side
    typedef dcache_lane_tap_t [`DCACHE_NUM_REQS-1:0] dcache_tap_t;

    // 0 .. DCACHE_NUM_REQS lanes
    typedef logic [$clog2(`DCACHE_NUM_REQS + 1)-1:0] lane_count_t;

endpackage

//--- rtl/perf_pkg.sv
// ############################################################
// fire sample, pending delta and counter result types
// ############################################################

`include "mem_perf_config.svh"

package perf_pkg;

    import mem_bus_pkg::*;

    // one performance counter
    typedef logic [`PERF_CTR_BITS-1:0] perf_ctr_t;

    // icache pending change per cycle, -1 .. +1
    typedef logic signed [1:0] icache_delta_t;

    // dcache pending change per cycle, -lanes .. +lanes
    typedef logic signed [3:0] dcache_delta_t;

    // fires seen in one bus cycle, registered once
    typedef struct packed {
        logic        ifetch;
        logic        iresp;
        lane_count_t loads;
        lane_count_t stores;
        lane_count_t dresp;
    } fire_sample_t;

    // what the monitor reports
    typedef struct packed {
        perf_ctr_t ifetches;
        perf_ctr_t loads;
        perf_ctr_t stores;
        perf_ctr_t ifetch_latency;
        perf_ctr_t load_latency;
    } perf_counters_t;

endpackage

//--- rtl/bus_fire_sampler.sv
// ############################################################
// sampling stage: bus fires, lane pop-counts, sample register
// ############################################################

`include "mem_perf_config.svh"

module bus_fire_sampler
    import mem_bus_pkg::*;
    import perf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  icache_tap_t  icache_tap,
    input  dcache_tap_t  dcache_tap,
    output fire_sample_t sample
);

    logic                        ifetch_fire;
    logic                        iresp_fire;
    logic [`DCACHE_NUM_REQS-1:0] load_fire;
    logic [`DCACHE_NUM_REQS-1:0] store_fire;
    logic [`DCACHE_NUM_REQS-1:0] dresp_fire;
    fire_sample_t                sample_next;

    function automatic lane_count_t pop_count(input logic [`DCACHE_NUM_REQS-1:0] bits);
        lane_count_t count;
        count = '0;
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            count = count + lane_count_t'(bits[i]);
        end
        return count;
    endfunction

    // icache handshakes
    assign ifetch_fire = icache_tap.req_valid && icache_tap.req_ready;
    assign iresp_fire  = icache_tap.rsp_valid && icache_tap.rsp_ready;

    // per-lane dcache handshakes, split by rw
    always_comb begin
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            load_fire[i]  = dcache_tap[i].req_valid && dcache_tap[i].req_ready
                            && !dcache_tap[i].req_rw;
            store_fire[i] = dcache_tap[i].req_valid && dcache_tap[i].req_ready
                            && dcache_tap[i].req_rw;
            dresp_fire[i] = dcache_tap[i].rsp_valid && dcache_tap[i].rsp_ready;
        end
    end

    always_comb begin
        sample_next.ifetch = ifetch_fire;
        sample_next.iresp  = iresp_fire;
        sample_next.loads  = pop_count(load_fire);
        sample_next.stores = pop_count(store_fire);
        sample_next.dresp  = pop_count(dresp_fire);
    end

    // requests and responses take the same single stage,
    // so both sides of a pending count stay aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            sample <= '0;
        end else begin
            sample <= sample_next;
        end
    end

    // an unknown valid or ready would turn into a bogus fire
    // and skew the pending counts for the rest of the run
    a_taps_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(icache_tap) && !$isunknown(dcache_tap)
    ) else $error("bus tap carries unknown bits");

endmodule

//--- rtl/pending_read_tracker.sv
// ############################################################
// pending read count and latency accumulator for one cache
// ############################################################

module pending_read_tracker
    import perf_pkg::*;
#(
    parameter type delta_t = icache_delta_t
) (
    input  logic      clk,
    input  logic      reset,
    input  delta_t    delta,
    output perf_ctr_t pending,
    output perf_ctr_t latency
);

    perf_ctr_t delta_ext;
    logic      delta_neg;
    perf_ctr_t delta_mag;

    // sign-extend the per-cycle change to counter width
    assign delta_ext = perf_ctr_t'($signed(delta));
    assign delta_neg = delta_ext[$bits(perf_ctr_t)-1];

    // magnitude of a draining step, used only by the check below
    assign delta_mag = delta_neg ? perf_ctr_t'(-delta_ext) : delta_ext;

    // two's complement add covers both fill and drain
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending + delta_ext;
        end
    end

    // every cycle a read stays outstanding costs one cycle of latency.
    // the registered pending value is used, so a read held k cycles
    // contributes exactly k
    always_ff @(posedge clk) begin
        if (reset) begin
            latency <= '0;
        end else begin
            latency <= latency + pending;
        end
    end

    // more responses than reads in flight means the sampler saw
    // a response without its request
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        delta_neg |-> (delta_mag <= pending)
    ) else $error("pending read count would go below zero");

endmodule

//--- rtl/access_counter.sv
// ############################################################
// fetch, load and store event counters
// ############################################################

`include "mem_perf_config.svh"

module access_counter
    import perf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  fire_sample_t sample,
    output perf_ctr_t    ifetches,
    output perf_ctr_t    loads,
    output perf_ctr_t    stores
);

    // one fetch at most per cycle, lanes add in bulk
    always_ff @(posedge clk) begin
        if (reset) begin
            ifetches <= '0;
            loads    <= '0;
            stores   <= '0;
        end else begin
            ifetches <= ifetches + perf_ctr_t'(sample.ifetch);
            loads    <= loads    + perf_ctr_t'(sample.loads);
            stores   <= stores   + perf_ctr_t'(sample.stores);
        end
    end

    // each lane fires at most one request, load or store,
    // so the sampler's two pop-counts share the lane budget
    a_lane_budget: assert property (
        @(posedge clk) disable iff (reset)
        (32'(sample.loads) + 32'(sample.stores)) <= `DCACHE_NUM_REQS
    ) else $error("loads plus stores exceed the lane count");

endmodule

//--- rtl/mem_perf_monitor.sv
// ############################################################
// memory traffic monitor top: sampler and accumulation stages
// ############################################################

module mem_perf_monitor
    import mem_bus_pkg::*;
    import perf_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  icache_tap_t    icache_tap,
    input  dcache_tap_t    dcache_tap,
    output perf_counters_t counters
);

    fire_sample_t  sample;
    icache_delta_t icache_delta;
    dcache_delta_t dcache_delta;
    perf_ctr_t     icache_pending;
    perf_ctr_t     dcache_pending;

    bus_fire_sampler u_sampler (
        .clk        (clk),
        .reset      (reset),
        .icache_tap (icache_tap),
        .dcache_tap (dcache_tap),
        .sample     (sample)
    );

    // net change in outstanding reads this sample.
    // stores never wait on a response here
    assign icache_delta = icache_delta_t'(sample.ifetch) - icache_delta_t'(sample.iresp);
    assign dcache_delta = dcache_delta_t'(sample.loads) - dcache_delta_t'(sample.dresp);

    pending_read_tracker #(
        .delta_t (icache_delta_t)
    ) u_icache_pending (
        .clk     (clk),
        .reset   (reset),
        .delta   (icache_delta),
        .pending (icache_pending),
        .latency (counters.ifetch_latency)
    );

    pending_read_tracker #(
        .delta_t (dcache_delta_t)
    ) u_dcache_pending (
        .clk     (clk),
        .reset   (reset),
        .delta   (dcache_delta),
        .pending (dcache_pending),
        .latency (counters.load_latency)
    );

    access_counter u_access (
        .clk      (clk),
        .reset    (reset),
        .sample   (sample),
        .ifetches (counters.ifetches),
        .loads    (counters.loads),
        .stores   (counters.stores)
    );

    // pending and event counts update on the same edge,
    // so reads in flight can never outnumber reads issued
    a_icache_pending_bound: assert property (
        @(posedge clk) disable iff (reset)
        icache_pending <= counters.ifetches
    ) else $error("icache pending reads exceed fetches issued");

    a_dcache_pending_bound: assert property (
        @(posedge clk) disable iff (reset)
        dcache_pending <= counters.loads
    ) else $error("dcache pending reads exceed loads issued");

endmodule

//--- tests/mem_perf_monitor_tb.sv
// ############################################################
// testbench for the memory traffic monitor, trace driven
// ############################################################

`include "mem_perf_config.svh"

module mem_perf_monitor_tb
    import mem_bus_pkg::*;
    import perf_pkg::*;
;

    localparam int    CLK_PERIOD = 8;
    localparam string TRACE_FILE = "tests/mem_perf_trace.txt";

    // one trace line: bus levels for one cycle and the counters seen in it
    typedef struct {
        int                          test_id;
        logic                        reset;
        icache_tap_t                 icache;
        logic [`DCACHE_NUM_REQS-1:0] req_valid;
        logic [`DCACHE_NUM_REQS-1:0] req_ready;
        logic [`DCACHE_NUM_REQS-1:0] req_rw;
        logic [`DCACHE_NUM_REQS-1:0] rsp_valid;
        logic [`DCACHE_NUM_REQS-1:0] rsp_ready;
        perf_counters_t              expected;
    } trace_entry_t;

    logic           clk = 1'b0;
    logic           reset;
    icache_tap_t    icache_tap;
    dcache_tap_t    dcache_tap;
    perf_counters_t counters;

    trace_entry_t   trace_q[$];
    bit             trace_ready = 1'b0;
    int             pass_count = 0;
    int             fail_count = 0;

    mem_perf_monitor u_mem_perf_monitor (
        .clk        (clk),
        .reset      (reset),
        .icache_tap (icache_tap),
        .dcache_tap (dcache_tap),
        .counters   (counters)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic dcache_tap_t build_dcache_tap(
        input logic [`DCACHE_NUM_REQS-1:0] req_valid,
        input logic [`DCACHE_NUM_REQS-1:0] req_ready,
        input logic [`DCACHE_NUM_REQS-1:0] req_rw,
        input logic [`DCACHE_NUM_REQS-1:0] rsp_valid,
        input logic [`DCACHE_NUM_REQS-1:0] rsp_ready
    );
        dcache_tap_t tap;
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            tap[i].req_valid = req_valid[i];
            tap[i].req_ready = req_ready[i];
            tap[i].req_rw    = req_rw[i];
            tap[i].rsp_valid = rsp_valid[i];
            tap[i].rsp_ready = rsp_ready[i];
        end
        return tap;
    endfunction

    task automatic load_trace(output bit ok);
        int                          fd;
        int                          cnt;
        string                       text;
        logic [3:0]                  itap;
        perf_ctr_t                   exp_val[5];
        trace_entry_t                entry;
        ok = 1'b1;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open trace file %s", TRACE_FILE);
            ok = 1'b0;
        end else begin
            while (!$feof(fd) && ok) begin
                text = "";
                cnt = $fgets(text, fd);
                // comment lines and blank lines carry no cycle
                if (cnt == 0 || text.getc(0) == "#") continue;
                cnt = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                              entry.test_id, entry.reset, itap,
                              entry.req_valid, entry.req_ready, entry.req_rw,
                              entry.rsp_valid, entry.rsp_ready,
                              exp_val[0], exp_val[1], exp_val[2], exp_val[3], exp_val[4]);
                if (cnt <= 0) continue;
                if (cnt != 13) begin
                    $display("trace line has %0d fields instead of 13: %s", cnt, text);
                    ok = 1'b0;
                end else begin
                    entry.icache                  = icache_tap_t'(itap);
                    entry.expected.ifetches       = exp_val[0];
                    entry.expected.loads          = exp_val[1];
                    entry.expected.stores         = exp_val[2];
                    entry.expected.ifetch_latency = exp_val[3];
                    entry.expected.load_latency   = exp_val[4];
                    trace_q.push_back(entry);
                end
            end
            $fclose(fd);
            if (ok && trace_q.size() == 0) begin
                $display("trace file holds no cycles");
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_value(input int line_no, input string name,
                               input perf_ctr_t expected, input perf_ctr_t actual);
        assert (actual === expected) pass_count++;
        else begin
            $display("CHECK FAILED line %0d %s: expected 0x%h, got 0x%h",
                     line_no, name, expected, actual);
            fail_count++;
        end
    endtask

    task automatic check_counters(input int line_no, input perf_counters_t expected);
        check_value(line_no, "ifetches", expected.ifetches, counters.ifetches);
        check_value(line_no, "loads", expected.loads, counters.loads);
        check_value(line_no, "stores", expected.stores, counters.stores);
        check_value(line_no, "ifetch_latency", expected.ifetch_latency,
                    counters.ifetch_latency);
        check_value(line_no, "load_latency", expected.load_latency, counters.load_latency);
    endtask

    initial begin : run_trace
        bit loaded;
        int test_lines;
        int test_fails_start;
        reset      = 1'b1;
        icache_tap = '0;
        dcache_tap = '0;
        load_trace(loaded);
        if (!loaded) begin
            $display("trace could not be loaded");
            $display("Simulation failed");
            $finish;
        end else begin
            trace_ready      = 1'b1;
            test_lines       = 0;
            test_fails_start = 0;
            for (int n = 0; n < trace_q.size(); n++) begin
                @(posedge clk);
                reset      <= trace_q[n].reset;
                icache_tap <= trace_q[n].icache;
                dcache_tap <= build_dcache_tap(trace_q[n].req_valid, trace_q[n].req_ready,
                                               trace_q[n].req_rw, trace_q[n].rsp_valid,
                                               trace_q[n].rsp_ready);
                // counters are settled by the falling edge
                @(negedge clk);
                check_counters(n, trace_q[n].expected);
                test_lines++;
                if (n == trace_q.size() - 1 || trace_q[n + 1].test_id != trace_q[n].test_id) begin
                    $display("test %0d finished: %0d lines, %0d failed checks",
                             trace_q[n].test_id, test_lines, fail_count - test_fails_start);
                    test_lines       = 0;
                    test_fails_start = fail_count;
                end
            end
            $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // budget of the trace length plus some slack
    initial begin : watchdog
        wait (trace_ready);
        #((trace_q.size() + 20) * CLK_PERIOD);
        $display("timeout: the trace did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tests/mem_perf_trace.txt
# test reset itap req_valid req_ready req_rw rsp_valid rsp_ready | ifetches loads stores ifetch_lat load_lat
# itap bits: req_valid req_ready rsp_valid rsp_ready; lane masks lane3..0; counters seen during the cycle
1 1 c f f 0 0 0 0 0 0 0 0
1 1 f 3 3 1 0 0 0 0 0 0 0
1 1 c f f f 0 0 0 0 0 0 0
1 1 3 0 0 0 f f 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0
2 0 c 0 0 0 0 0 0 0 0 0 0
2 0 8 0 0 0 0 0 0 0 0 0 0
2 0 3 0 0 0 0 0 1 0 0 0 0
2 0 c 0 0 0 0 0 1 0 0 1 0
2 0 0 0 0 0 0 0 1 0 0 2 0
2 0 0 0 0 0 0 0 2 0 0 2 0
2 0 3 0 0 0 0 0 2 0 0 3 0
2 0 0 0 0 0 0 0 2 0 0 4 0
3 0 0 f f a 0 0 2 0 0 5 0
3 0 0 f 0 0 0 0 2 0 0 5 0
3 0 0 7 5 4 0 0 2 2 2 5 0
3 0 0 0 0 0 5 5 2 2 2 5 2
3 0 0 0 0 0 3 1 2 3 3 5 4
3 0 0 0 0 0 0 0 2 3 3 5 7
4 0 0 3 3 0 0 0 2 3 3 5 8
4 0 0 c c 8 0 0 2 3 3 5 8
4 0 0 1 1 0 0 0 2 5 3 5 8
4 0 0 0 0 0 4 4 2 6 4 5 a
4 0 0 0 0 0 0 0 2 7 4 5 d
4 0 0 0 0 0 3 3 2 7 4 5 11
4 0 0 2 2 2 1 0 2 7 4 5 14
4 0 0 0 0 0 1 1 2 7 4 5 17
5 0 c f f 6 0 0 2 7 5 5 18
5 0 c 0 0 0 8 8 2 7 5 5 19
5 0 f 1 1 0 0 0 3 9 7 5 19
5 0 3 0 0 0 1 1 4 9 7 6 1b
5 0 8 f 0 0 6 2 5 a 7 8 1c
5 0 c 8 8 8 0 0 5 a 7 a 1e
5 0 3 0 0 0 0 0 5 a 7 b 1f
5 0 3 0 0 0 0 0 6 a 8 c 1f
5 0 0 3 3 1 0 0 6 a 8 e 1f
5 0 c 0 0 0 2 2 6 a 8 f 1f
5 0 3 0 0 0 0 0 6 b 9 f 1f
5 0 0 0 0 0 0 0 7 b 9 f 20
5 0 0 0 0 0 0 0 7 b 9 10 20
5 0 0 0 0 0 0 0 7 b 9 10 20

//--- mem_perf_monitor.f
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/perf_pkg.sv
rtl/bus_fire_sampler.sv
rtl/pending_read_tracker.sv
rtl/access_counter.sv
rtl/mem_perf_monitor.sv
tests/mem_perf_monitor_tb.sv

//--- Bender.yml
package:
  name: mem_perf_monitor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_bus_pkg.sv
      - rtl/perf_pkg.sv
      - rtl/bus_fire_sampler.sv
      - rtl/pending_read_tracker.sv
      - rtl/access_counter.sv
      - rtl/mem_perf_monitor.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tests/mem_perf_monitor_tb.sv
